/* fb_pkg.sv */
////////////////////////////////////////
// Display subsystem shared package
// Bus structs, register map, timing constants
////////////////////////////////////////
package fb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } video_sync_t;

    typedef struct packed {
        logic [11:0] bytes;     // Burst length in bytes
        logic [23:0] addr;
    } dma_req_t;

    typedef struct packed {
        logic        last;      // Final beat of the burst
        logic [23:0] addr;
        logic [63:0] data;      // Four RGB565 pixels
    } dma_rsp_t;

    typedef struct packed {
        logic        enable;
        logic [11:0] width_m1;
        logic [11:0] height_m1;
    } fb_cfg_t;

    // Register offsets
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_WIDTH  = 8'h04;
    localparam logic [7:0] REG_HEIGHT = 8'h08;
    localparam logic [7:0] REG_FRAMES = 8'h0C;

    // Short blanking so a frame simulates quickly
    localparam int unsigned H_FRONT = 4;    // Pixels
    localparam int unsigned H_SYNC  = 4;
    localparam int unsigned H_BACK  = 24;
    localparam int unsigned V_FRONT = 1;    // Lines
    localparam int unsigned V_SYNC  = 1;
    localparam int unsigned V_BACK  = 2;

    localparam logic [11:0] BURST_BYTES     = 12'd64;
    localparam int unsigned RING_ABITS      = 6;
    localparam int unsigned FETCH_THRESHOLD = 96;   // Words

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQUEST,
        FETCH_WRITING,
        FETCH_END_OF_FRAME
    } fetch_state_e;

endpackage

/* fb_apb_regs.sv */
////////////////////////////////////////
// APB control registers
// Size, enable and a frame counter
////////////////////////////////////////
module fb_apb_regs import fb_pkg::*; (
    input  logic     i_clk,
    input  logic     i_nrst,
    input  apb_req_t i_apb,
    output apb_rsp_t o_apb,
    input  logic     i_frame_start,
    output fb_cfg_t  o_cfg
);

    fb_cfg_t     cfg_q;
    logic [15:0] frames_q;
    logic        access;
    logic        addr_ok;
    logic [31:0] rdata;

    assign access = i_apb.psel && i_apb.penable;

    // Read decode
    always_comb begin
        rdata   = '0;
        addr_ok = 1'b1;
        case (i_apb.paddr)
            REG_CTRL:   rdata = {31'd0, cfg_q.enable};
            REG_WIDTH:  rdata = {20'd0, cfg_q.width_m1};
            REG_HEIGHT: rdata = {20'd0, cfg_q.height_m1};
            REG_FRAMES: rdata = {16'd0, frames_q};
            default:    addr_ok = 1'b0;
        endcase
    end

    assign o_apb.prdata  = rdata;
    assign o_apb.pready  = 1'b1;                // No wait states
    assign o_apb.pslverr = access &&
                           (!addr_ok || (i_apb.pwrite && i_apb.paddr == REG_FRAMES));

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cfg_q    <= '0;
            frames_q <= '0;
        end else begin
            if (access && i_apb.pwrite) begin
                case (i_apb.paddr)
                    REG_CTRL:   cfg_q.enable    <= i_apb.pwdata[0];
                    REG_WIDTH:  cfg_q.width_m1  <= i_apb.pwdata[11:0];
                    REG_HEIGHT: cfg_q.height_m1 <= i_apb.pwdata[11:0];
                    default:    ;                   // Frame counter is read-only
                endcase
            end
            if (i_frame_start) begin
                frames_q <= frames_q + 16'd1;
            end
        end
    end

    assign o_cfg = cfg_q;

endmodule

/* fb_video_timing.sv */
////////////////////////////////////////
// Video timing generator
// Hsync, vsync and de from the active size
////////////////////////////////////////
module fb_video_timing import fb_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  fb_cfg_t     i_cfg,
    output video_sync_t o_sync,
    output logic        o_frame_start
);

    logic [12:0] h_cnt;
    logic [12:0] v_cnt;
    logic [12:0] hs_start;
    logic [12:0] h_last;
    logic [12:0] vs_start;
    logic [12:0] v_last;
    video_sync_t sync_q;
    logic        start_q;

    // Porch boundaries follow the active size
    assign hs_start = {1'b0, i_cfg.width_m1} + 13'(1 + H_FRONT);
    assign h_last   = {1'b0, i_cfg.width_m1} + 13'(H_FRONT + H_SYNC + H_BACK);
    assign vs_start = {1'b0, i_cfg.height_m1} + 13'(1 + V_FRONT);
    assign v_last   = {1'b0, i_cfg.height_m1} + 13'(V_FRONT + V_SYNC + V_BACK);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            h_cnt   <= '0;
            v_cnt   <= '0;
            sync_q  <= '0;
            start_q <= 1'b0;
        end else if (!i_cfg.enable) begin
            h_cnt   <= '0;      // Parked until enabled
            v_cnt   <= '0;
            sync_q  <= '0;
            start_q <= 1'b0;
        end else begin
            if (h_cnt == h_last) begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == v_last) ? 13'd0 : v_cnt + 13'd1;
            end else begin
                h_cnt <= h_cnt + 13'd1;
            end
            sync_q.de    <= (h_cnt <= {1'b0, i_cfg.width_m1}) &&
                            (v_cnt <= {1'b0, i_cfg.height_m1});
            sync_q.hsync <= (h_cnt >= hs_start) && (h_cnt < hs_start + 13'(H_SYNC));
            sync_q.vsync <= (v_cnt >= vs_start) && (v_cnt < vs_start + 13'(V_SYNC));
            // First cycle of vertical sync
            start_q      <= (v_cnt == vs_start) && (h_cnt == 13'd0);
        end
    end

    assign o_sync        = sync_q;
    assign o_frame_start = start_q;

endmodule

/* fb_line_ram.sv */
////////////////////////////////////////
// Line ring RAM, 64 x 64 bit
////////////////////////////////////////
module fb_line_ram import fb_pkg::*; (
    input  logic                  i_clk,
    input  logic [RING_ABITS-1:0] i_addr,
    input  logic                  i_wena,
    input  logic [63:0]           i_wdata,
    output logic [63:0]           o_rdata
);

    logic [63:0] mem [2**RING_ABITS];

    always_ff @(posedge i_clk) begin
        if (i_wena) begin
            mem[i_addr] <= i_wdata;
        end else begin
            o_rdata <= mem[i_addr];     // Registered read
        end
    end

endmodule

/* framebuf.sv */
////////////////////////////////////////
// Frame buffer with DMA line fetch into four rings
// and RGB565 pixel output behind delayed sync
////////////////////////////////////////
module framebuf import fb_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  fb_cfg_t     i_cfg,
    input  video_sync_t i_sync,
    output video_sync_t o_sync,
    output logic [15:0] o_rgb565,
    output logic        o_req_valid,
    output dma_req_t    o_req,
    input  logic        i_req_ready,
    input  logic        i_resp_valid,
    input  dma_rsp_t    i_resp,
    output logic        o_resp_ready
);

    localparam int unsigned PW = RING_ABITS + 3;    // Wrap bit, ring index, word

    fetch_state_e  state;
    logic          req_valid;
    dma_req_t      req_q;
    logic          resp_ready;
    logic [PW-1:0] wr_pos;
    logic [PW-1:0] rd_pos;
    logic [11:0]   wr_col;
    logic [11:0]   wr_row;
    logic [PW-1:0] fill;
    logic [24:0]   fetch_addr;
    logic          req_fire;
    logic          beat_fire;
    logic          row_done;
    logic          fetch_need;
    logic          vsync_rise;
    logic          rewind;
    video_sync_t   sync_d0;
    video_sync_t   sync_d1;
    logic [3:0]    mux_ena;
    logic [3:0]    lane_q;
    logic [1:0]    ring_q;
    logic [63:0]   ram_rdata [4];
    logic [63:0]   ring_word;
    logic [15:0]   lane_pix;
    logic [15:0]   rgb_q;

    assign req_fire   = req_valid && i_req_ready;
    assign beat_fire  = i_resp_valid && resp_ready;
    assign row_done   = ({1'b0, wr_col} + 13'd3) >= {1'b0, i_cfg.width_m1};
    assign fill       = wr_pos - rd_pos;                    // Words held including gaps
    assign fetch_need = (fill[PW-1] || fill <= PW'(FETCH_THRESHOLD)) &&
                        (wr_row <= i_cfg.height_m1);
    assign fetch_addr = {wr_row, 13'd0} + {12'd0, wr_col, 1'b0};
    assign vsync_rise = i_sync.vsync && !sync_d0.vsync;
    // Restart both pointers once vsync is gone and no burst is open
    assign rewind     = (state == FETCH_END_OF_FRAME) && !i_sync.vsync &&
                        !req_valid && !resp_ready;

    // Fetch FSM and write side
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state      <= FETCH_IDLE;
            req_valid  <= 1'b0;
            req_q      <= '0;
            resp_ready <= 1'b0;
            wr_pos     <= '0;
            wr_col     <= '0;
            wr_row     <= '0;
        end else begin
            if (req_fire) begin
                req_valid  <= 1'b0;
                resp_ready <= 1'b1;
            end
            if (beat_fire) begin
                wr_pos <= {wr_pos[PW-1:RING_ABITS], wr_pos[RING_ABITS-1:0] + RING_ABITS'(1)};
                wr_col <= wr_col + 12'd4;                   // Four pixels per beat
                if (i_resp.last) begin
                    resp_ready <= 1'b0;
                    if (row_done) begin
                        wr_pos <= {wr_pos[PW-1:RING_ABITS] + 3'd1, {RING_ABITS{1'b0}}};
                        wr_col <= '0;
                        wr_row <= wr_row + 12'd1;
                    end
                end
            end
            case (state)
                FETCH_IDLE: if (fetch_need) begin
                    req_valid  <= 1'b1;
                    req_q.bytes <= BURST_BYTES;
                    req_q.addr  <= fetch_addr[23:0];
                    state      <= FETCH_REQUEST;
                end
                FETCH_REQUEST: if (req_fire) begin
                    state <= FETCH_WRITING;
                end
                FETCH_WRITING: if (beat_fire && i_resp.last) begin
                    state <= FETCH_IDLE;
                end
                default: if (rewind) begin
                    wr_pos <= '0;
                    wr_col <= '0;
                    wr_row <= '0;
                    state  <= FETCH_IDLE;
                end
            endcase
            if (vsync_rise) begin
                state <= FETCH_END_OF_FRAME;
            end
        end
    end

    // Read side, sync delay and pixel register
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            sync_d0 <= '0;
            sync_d1 <= '0;
            rd_pos  <= '0;
            mux_ena <= 4'b0001;
            lane_q  <= 4'b0001;
            ring_q  <= '0;
            rgb_q   <= '0;
        end else begin
            sync_d0 <= i_sync;
            sync_d1 <= sync_d0;
            lane_q  <= mux_ena;
            ring_q  <= rd_pos[RING_ABITS+1:RING_ABITS];
            rgb_q   <= sync_d0.de ? lane_pix : 16'd0;
            if (rewind) begin
                rd_pos  <= '0;
                mux_ena <= 4'b0001;
            end else if (i_sync.de) begin
                mux_ena <= {mux_ena[2:0], mux_ena[3]};
                // Word address holds for all four lanes
                if (mux_ena[3]) begin
                    rd_pos <= {rd_pos[PW-1:RING_ABITS],
                               rd_pos[RING_ABITS-1:0] + RING_ABITS'(1)};
                end
            end else if (sync_d0.de) begin
                rd_pos  <= {rd_pos[PW-1:RING_ABITS] + 3'd1, {RING_ABITS{1'b0}}};  // Next line
                mux_ena <= 4'b0001;
            end
        end
    end

    for (genvar g = 0; g < 4; g++) begin : g_ring
        logic                  we;
        logic [RING_ABITS-1:0] addr;

        assign we   = beat_fire && (wr_pos[RING_ABITS+1:RING_ABITS] == 2'(g));
        assign addr = we ? wr_pos[RING_ABITS-1:0] : rd_pos[RING_ABITS-1:0];

        fb_line_ram u_ring (
            .i_clk   (i_clk),
            .i_addr  (addr),
            .i_wena  (we),
            .i_wdata (i_resp.data),
            .o_rdata (ram_rdata[g])
        );
    end

    always_comb begin
        ring_word = ram_rdata[ring_q];
        case (lane_q)
            4'b0001: lane_pix = ring_word[15:0];
            4'b0010: lane_pix = ring_word[31:16];
            4'b0100: lane_pix = ring_word[47:32];
            default: lane_pix = ring_word[63:48];
        endcase
    end

    assign o_sync       = sync_d1;
    assign o_rgb565     = rgb_q;
    assign o_req_valid  = req_valid;
    assign o_req        = req_q;
    assign o_resp_ready = resp_ready;

endmodule

/* fb_display_top.sv */
////////////////////////////////////////
// Display scan-out top level
////////////////////////////////////////
module fb_display_top import fb_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  apb_req_t    i_apb,
    output apb_rsp_t    o_apb,
    output video_sync_t o_sync,
    output logic [15:0] o_rgb565,
    output logic        o_req_valid,
    output dma_req_t    o_req,
    input  logic        i_req_ready,
    input  logic        i_resp_valid,
    input  dma_rsp_t    i_resp,
    output logic        o_resp_ready
);

    fb_cfg_t     cfg;
    video_sync_t vt_sync;       // Undelayed timing
    logic        frame_start;

    fb_apb_regs u_regs (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_apb         (i_apb),
        .o_apb         (o_apb),
        .i_frame_start (frame_start),
        .o_cfg         (cfg)
    );

    fb_video_timing u_timing (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_cfg         (cfg),
        .o_sync        (vt_sync),
        .o_frame_start (frame_start)
    );

    framebuf u_fb (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_cfg        (cfg),
        .i_sync       (vt_sync),
        .o_sync       (o_sync),
        .o_rgb565     (o_rgb565),
        .o_req_valid  (o_req_valid),
        .o_req        (o_req),
        .i_req_ready  (i_req_ready),
        .i_resp_valid (i_resp_valid),
        .i_resp       (i_resp),
        .o_resp_ready (o_resp_ready)
    );

endmodule

/* tb_fb_mem.sv */
////////////////////////////////////////
// Frame memory model for the DMA port
// Pixel pattern and throttled request ready
////////////////////////////////////////
module tb_fb_mem import fb_pkg::*; (
    input  logic     i_clk,
    input  logic     i_nrst,
    input  logic     i_req_valid,
    input  dma_req_t i_req,
    output logic     o_req_ready = 1'b0,
    output logic     o_resp_valid = 1'b0,
    output dma_rsp_t o_resp = '0
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] lfsr = 32'heb194d11;
    logic        valid_s = 1'b0;    // Request seen before the last rising edge
    logic        ready_s = 1'b0;
    dma_req_t    req_s = '0;
    logic        busy = 1'b0;
    logic [23:0] base = '0;
    int          beat = 0;
    int          nbeats = 0;

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] beat_data(input logic [23:0] addr);
        logic [63:0] d;
        logic [10:0] row;
        logic [11:0] col;
        row = addr[23:13];
        for (int k = 0; k < 4; k++) begin
            col = 12'(addr[12:1]) + 12'(k);
            d[16*k +: 16] = {row[7:0], col[7:0]};
        end
        return d;
    endfunction

    always @(negedge i_clk) begin
        logic b0;
        logic b1;
        if (!i_nrst) begin
            o_req_ready  = 1'b0;
            o_resp_valid = 1'b0;
            busy         = 1'b0;
        end else begin
            if (busy && beat == nbeats) begin
                busy         = 1'b0;
                o_resp_valid = 1'b0;
            end
            if (valid_s && ready_s && !busy) begin  // Accepted on the last edge
                busy   = 1'b1;
                beat   = 0;
                base   = req_s.addr;
                nbeats = int'(req_s.bytes) / 8;
            end
            if (busy) begin
                o_resp_valid = 1'b1;
                o_resp.addr  = base + 24'(8 * beat);
                o_resp.data  = beat_data(o_resp.addr);
                o_resp.last  = (beat == nbeats - 1);
                beat++;
            end
            b0 = lfsr_bit();
            b1 = lfsr_bit();
            o_req_ready = !(b0 && b1);          // Stall about one cycle in four
        end
        valid_s = i_req_valid;
        ready_s = o_req_ready;
        req_s   = i_req;
    end

endmodule

/* tb_fb_display.sv */
////////////////////////////////////////
// Testbench for the display scan-out top
////////////////////////////////////////
module tb_fb_display import fb_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic        wr;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] exp_rdata;
        logic        exp_err;
    } apb_step_t;

    logic        i_clk = 1'b0;
    logic        i_nrst = 1'b0;
    apb_req_t    i_apb = '0;
    apb_rsp_t    o_apb;
    video_sync_t o_sync;
    logic [15:0] o_rgb565;
    logic        req_valid;
    dma_req_t    req;
    logic        req_ready;
    logic        resp_valid;
    dma_rsp_t    resp;
    logic        resp_ready;

    int value_errs = 0;
    int other_errs = 0;
    logic mon_on = 1'b0;
    int frame_idx = 0;
    int row = 0;
    int col = 0;
    int de_len = 0;
    int lines = 0;
    int stalls = 0;
    logic prev_de = 1'b0;
    logic prev_vs = 1'b0;
    logic prev_valid = 1'b0;
    logic prev_ready = 1'b0;
    dma_req_t prev_req = '0;

    apb_step_t steps [8];

    always #4 i_clk = ~i_clk;

    fb_display_top UUT (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_apb        (i_apb),
        .o_apb        (o_apb),
        .o_sync       (o_sync),
        .o_rgb565     (o_rgb565),
        .o_req_valid  (req_valid),
        .o_req        (req),
        .i_req_ready  (req_ready),
        .i_resp_valid (resp_valid),
        .i_resp       (resp),
        .o_resp_ready (resp_ready)
    );

    tb_fb_mem u_mem (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (req_valid),
        .i_req        (req),
        .o_req_ready  (req_ready),
        .o_resp_valid (resp_valid),
        .o_resp       (resp)
    );

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // One APB transfer with setup and access phase
    task automatic apb_access(input apb_step_t s);
        @(negedge i_clk);
        i_apb.psel    = 1'b1;
        i_apb.penable = 1'b0;
        i_apb.pwrite  = s.wr;
        i_apb.paddr   = s.addr;
        i_apb.pwdata  = s.data;
        @(negedge i_clk);
        i_apb.penable = 1'b1;
        #2;
        check("pready", 64'(o_apb.pready), 64'd1);
        check("pslverr", 64'(o_apb.pslverr), 64'(s.exp_err));
        if (!s.wr && !s.exp_err) begin
            check("prdata", 64'(o_apb.prdata), 64'(s.exp_rdata));
        end
        @(negedge i_clk);
        i_apb.psel    = 1'b0;
        i_apb.penable = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int cycles;
        cycles = 0;
        while (frame_idx < n && cycles < 5000) begin
            @(negedge i_clk);
            cycles++;
        end
        if (frame_idx < n) begin
            other_errs++;
            $display("Timed out waiting for vsync pulse %0d", n);
        end
    endtask

    // Output monitor sampled in the middle of the low clock phase
    always @(negedge i_clk) begin
        #2;
        if (mon_on) begin
            if (o_sync.de) begin
                if (frame_idx >= 1) begin
                    check("o_rgb565", 64'(o_rgb565), 64'({row[7:0], col[7:0]}));
                end
                col++;
                de_len++;
            end else begin
                check("o_rgb565", 64'(o_rgb565), 64'd0);
            end
            if (prev_de && !o_sync.de) begin
                if (frame_idx >= 1) begin
                    check("de_cycles", 64'(de_len), 64'd16);
                end
                lines++;
                row++;
                col    = 0;
                de_len = 0;
            end
            if (o_sync.vsync && !prev_vs) begin
                if (frame_idx >= 1) begin
                    check("de_lines", 64'(lines), 64'd4);
                end
                frame_idx++;
                row   = 0;
                col   = 0;
                lines = 0;
            end
            if (prev_valid && !prev_ready) begin
                stalls++;
                check("o_req_valid", 64'(req_valid), 64'd1);
                check("o_req", 64'(req), 64'(prev_req));
            end
            if (resp_valid) begin
                check("o_resp_ready", 64'(resp_ready), 64'd1);  // Beats are never stalled
            end
            prev_de    = o_sync.de;
            prev_vs    = o_sync.vsync;
            prev_valid = req_valid;
            prev_ready = req_ready;
            prev_req   = req;
        end
    end

    initial begin
        apb_step_t enable_wr;
        apb_step_t frames_rd;

        steps[0] = '{1'b1, REG_WIDTH,  32'd15, 32'd0,  1'b0};
        steps[1] = '{1'b1, REG_HEIGHT, 32'd3,  32'd0,  1'b0};
        steps[2] = '{1'b0, REG_WIDTH,  32'd0,  32'd15, 1'b0};
        steps[3] = '{1'b0, REG_HEIGHT, 32'd0,  32'd3,  1'b0};
        steps[4] = '{1'b0, REG_CTRL,   32'd0,  32'd0,  1'b0};
        steps[5] = '{1'b0, 8'h10,      32'd0,  32'd0,  1'b1};   // Unmapped offset
        steps[6] = '{1'b1, REG_FRAMES, 32'd5,  32'd0,  1'b1};
        steps[7] = '{1'b0, REG_FRAMES, 32'd0,  32'd0,  1'b0};

        repeat (5) @(negedge i_clk);
        i_nrst = 1'b1;
        mon_on = 1'b1;

        foreach (steps[i]) begin
            apb_access(steps[i]);
        end

        // Timing must stay parked while disabled
        repeat (500) begin
            @(negedge i_clk);
            #2;
            check("o_sync", 64'(o_sync), 64'd0);
        end

        enable_wr = '{1'b1, REG_CTRL, 32'd1, 32'd0, 1'b0};
        apb_access(enable_wr);
        wait_frames(3);

        frames_rd = '{1'b0, REG_FRAMES, 32'd0, 32'd3, 1'b0};
        apb_access(frames_rd);

        if (stalls == 0) begin
            other_errs++;
            $display("Request ready was never throttled during a pending request");
        end

        $display("Errors: value mismatches %0d, other failures %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
fb_pkg.sv
fb_apb_regs.sv
fb_video_timing.sv
fb_line_ram.sv
framebuf.sv
fb_display_top.sv
tb_fb_mem.sv
tb_fb_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the display testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_fb_display -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi

if ! grep -q "STATUS: PASS" sim.log; then
    echo "Simulation ended without a result, see sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0
